/* design/gpu_pkg.sv */
/*
 * shared definitions for the foreground (sprite) layer
 *   - vector typedefs for positions, VRAM, objects and colour
 *   - screen geometry and sync windows
 *   - object table sizes and line buffer length
 *   - VRAM window map and object attribute field positions
 */
package gpu_pkg;

    // ------------------------------------------------------------------
    // vector types
    // ------------------------------------------------------------------
    typedef logic [8:0]  pos_t;
    typedef logic [11:0] vram_addr_t;
    typedef logic [7:0]  vram_data_t;
    typedef logic [5:0]  obj_index_t;
    typedef logic [6:0]  slot_t;
    typedef logic [31:0] obj_attr_t;
    typedef logic [4:0]  pmfa_t;
    typedef logic [15:0] pattern_line_t;
    typedef logic [2:0]  color_t;
    typedef logic [1:0]  channel_t;

    // ------------------------------------------------------------------
    // geometry
    // ------------------------------------------------------------------
    localparam int H_TOTAL     = 400;
    localparam int H_VISIBLE   = 256;
    localparam int HSYNC_START = 328;
    localparam int HSYNC_END   = 376;
    localparam int NUM_ROWS    = 523;
    localparam int LINE_REPEAT = 2;
    localparam int NUM_LINES   = 262;
    localparam int V_VISIBLE   = 240;
    // vsync low for logical lines 250 and 251
    localparam int VSYNC_START = 250;
    localparam int VSYNC_END   = 252;

    // objects
    localparam int    NUM_OBJECTS  = 64;
    localparam int    SPRITE_SIZE  = 8;
    localparam slot_t SLOT_EMPTY   = slot_t'(NUM_OBJECTS);
    localparam int    LINE_BUF_LEN = H_VISIBLE + SPRITE_SIZE;

    // ------------------------------------------------------------------
    // VRAM windows
    // ------------------------------------------------------------------
    localparam vram_addr_t PMF_BASE  = 12'h000;
    localparam int         PMF_BYTES = 512;
    localparam vram_addr_t OBM_BASE  = 12'h800;
    localparam int         OBM_BYTES = 256;

    // field positions inside obj_attr_t, byte k sits at bits 8k+7:8k
    localparam int ATTR_X_LSB     = 0;
    localparam int ATTR_Y_LSB     = 8;
    localparam int ATTR_PMFA_LSB  = 16;
    localparam int ATTR_VFLIP_BIT = 21;
    localparam int ATTR_HFLIP_BIT = 22;
    localparam int ATTR_COLOR_LSB = 24;

endpackage

/* design/gpu_ifs.sv */
/*
 * interfaces inside the foreground layer
 *   - video_timing_if : pixel position and sync levels
 *   - sprite_mem_if   : three combinational read ports of the sprite memories
 */
interface video_timing_if;
    gpu_pkg::pos_t x;
    gpu_pkg::pos_t y;
    logic          hsync;
    logic          vsync;

    modport src  (output x, y, hsync, vsync);
    modport sink (input  x, y, hsync, vsync);
endinterface

interface sprite_mem_if;
    // object parse port for the line builder
    gpu_pkg::obj_index_t parse_index;
    gpu_pkg::obj_attr_t  parse_attr;
    // object and pattern ports for the pixel stage
    gpu_pkg::obj_index_t draw_index;
    gpu_pkg::obj_attr_t  draw_attr;
    // pattern number followed by row within the pattern
    logic [$bits(gpu_pkg::pmfa_t)+2:0] pattern_sel;
    gpu_pkg::pattern_line_t            pattern_line;

    modport mem     (input  parse_index, draw_index, pattern_sel,
                     output parse_attr, draw_attr, pattern_line);
    modport builder (output parse_index, input parse_attr);
    modport pixel   (output draw_index, pattern_sel, input draw_attr, pattern_line);
endinterface

/* design/video_timing.sv */
/*
 * video timing generator
 *   - pixel counter and physical row counter
 *   - logical line from the row count and the line repeat
 *   - active-low hsync and vsync decode
 */
module video_timing (
    input  logic               clk_12_5875,
    input  logic               rst_n,
    video_timing_if.src        vt
);

    gpu_pkg::pos_t                         x_cnt;
    logic [$clog2(gpu_pkg::NUM_ROWS)-1:0]  row_cnt;

    // ------------------------------------------------------------------
    // counters
    // ------------------------------------------------------------------
    always_ff @(posedge clk_12_5875) begin
        if (!rst_n) begin
            x_cnt   <= '0;
            row_cnt <= '0;
        end else if (x_cnt == gpu_pkg::pos_t'(gpu_pkg::H_TOTAL - 1)) begin
            x_cnt <= '0;
            // row wraps at the end of the frame
            if (row_cnt == ($bits(row_cnt))'(gpu_pkg::NUM_ROWS - 1)) begin
                row_cnt <= '0;
            end else begin
                row_cnt <= row_cnt + 1'b1;
            end
        end else begin
            x_cnt <= x_cnt + 1'b1;
        end
    end

    assign vt.x = x_cnt;
    // each logical line spans LINE_REPEAT physical rows, the last line only one
    assign vt.y = gpu_pkg::pos_t'(row_cnt / gpu_pkg::LINE_REPEAT);

    // ------------------------------------------------------------------
    // sync decode
    // ------------------------------------------------------------------
    assign vt.hsync = !((x_cnt >= gpu_pkg::HSYNC_START) && (x_cnt < gpu_pkg::HSYNC_END));
    assign vt.vsync = !((vt.y >= gpu_pkg::VSYNC_START) && (vt.y < gpu_pkg::VSYNC_END));

    // counters stay inside the frame
    a_counters_in_range: assert property (
        @(posedge clk_12_5875) disable iff (!rst_n)
        (x_cnt < gpu_pkg::H_TOTAL) && (row_cnt < gpu_pkg::NUM_ROWS)
    );

endmodule

/* design/sprite_memory.sv */
/*
 * sprite memories written through the byte-wide VRAM port
 *   - window decode for pattern memory and object memory
 *   - pattern memory: 32 patterns, 8 rows, 2 bytes per row
 *   - object memory: 64 objects of 4 bytes
 *   - combinational reads for parse, draw and pattern row
 */
module sprite_memory (
    input  logic                  clk_12_5875,
    input  gpu_pkg::vram_addr_t   vram_addr,
    input  gpu_pkg::vram_data_t   vram_data,
    input  logic                  vram_we,
    sprite_mem_if.mem             mem
);

    gpu_pkg::vram_data_t pmf [gpu_pkg::PMF_BYTES];
    gpu_pkg::vram_data_t obm [gpu_pkg::OBM_BYTES];

    gpu_pkg::vram_addr_t pmf_off;
    gpu_pkg::vram_addr_t obm_off;
    logic                in_pmf;
    logic                in_obm;

    // ------------------------------------------------------------------
    // write side
    // ------------------------------------------------------------------
    assign pmf_off = vram_addr - gpu_pkg::PMF_BASE;
    assign obm_off = vram_addr - gpu_pkg::OBM_BASE;

    // offsets below a window base wrap to large values and fail the check
    assign in_pmf = pmf_off < gpu_pkg::PMF_BYTES;
    assign in_obm = obm_off < gpu_pkg::OBM_BYTES;

    always_ff @(posedge clk_12_5875) begin
        if (vram_we) begin
            if (in_pmf) begin
                pmf[pmf_off[$clog2(gpu_pkg::PMF_BYTES)-1:0]] <= vram_data;
            end
            if (in_obm) begin
                obm[obm_off[$clog2(gpu_pkg::OBM_BYTES)-1:0]] <= vram_data;
            end
        end
    end

    // ------------------------------------------------------------------
    // read side
    // ------------------------------------------------------------------

    // gather the four attribute bytes, byte 0 in the low bits
    function automatic gpu_pkg::obj_attr_t read_obj(gpu_pkg::obj_index_t idx);
        gpu_pkg::obj_attr_t attr;
        attr = {obm[{idx, 2'd3}], obm[{idx, 2'd2}], obm[{idx, 2'd1}], obm[{idx, 2'd0}]};
        return attr;
    endfunction

    assign mem.parse_attr = read_obj(mem.parse_index);
    assign mem.draw_attr  = read_obj(mem.draw_index);

    // even byte holds pixels 0..3, so it lands in the upper half
    assign mem.pattern_line = {pmf[{mem.pattern_sel, 1'b0}], pmf[{mem.pattern_sel, 1'b1}]};

endmodule

/* design/scanline_builder.sv */
/*
 * scanline builder for the foreground layer
 *   - object parse over the first 64 clocks of a line's first row
 *   - vertical overlap test against the next line
 *   - eight-entry fill of the back line buffer
 *   - buffer swap with clear of the new back buffer
 *   - front buffer lookup at the current x
 */
module scanline_builder (
    input  logic               clk_12_5875,
    input  logic               rst_n,
    video_timing_if.sink       vt,
    sprite_mem_if.builder      mem,
    output gpu_pkg::slot_t     draw_slot
);

    gpu_pkg::slot_t line_buf [2][gpu_pkg::LINE_BUF_LEN];

    logic                buf_sel;
    logic                swap_done;
    logic                first_row;

    logic                parse_en;
    logic                swap_row;
    logic                swap;
    logic                hit;
    gpu_pkg::pos_t       next_y;
    gpu_pkg::pos_t       obj_top;
    gpu_pkg::pos_t       fill_base;
    gpu_pkg::vram_data_t obj_x;
    gpu_pkg::vram_data_t obj_y;

    // ------------------------------------------------------------------
    // parse control
    // ------------------------------------------------------------------

    // object 63 at x=0 down to object 0 at x=63, lowest index written last
    assign mem.parse_index = gpu_pkg::obj_index_t'(gpu_pkg::NUM_OBJECTS - 1) - vt.x[5:0];

    assign parse_en = first_row && (vt.x < gpu_pkg::NUM_OBJECTS);
    assign next_y   = (vt.y == gpu_pkg::pos_t'(gpu_pkg::NUM_LINES - 1)) ? '0 : vt.y + 1'b1;

    assign obj_x     = mem.parse_attr[gpu_pkg::ATTR_X_LSB +: 8];
    assign obj_y     = mem.parse_attr[gpu_pkg::ATTR_Y_LSB +: 8];
    assign obj_top   = {1'b0, obj_y};
    assign fill_base = {1'b0, obj_x};

    assign hit = parse_en && (obj_top <= next_y)
               && (next_y <= obj_top + gpu_pkg::pos_t'(gpu_pkg::SPRITE_SIZE - 1));

    // the last line of the frame has a single row, so it swaps in that row
    assign swap_row = !first_row || (vt.y == gpu_pkg::pos_t'(gpu_pkg::NUM_LINES - 1));
    assign swap     = swap_row && !vt.hsync && !swap_done;

    // ------------------------------------------------------------------
    // line buffers
    // ------------------------------------------------------------------
    always_ff @(posedge clk_12_5875) begin
        if (!rst_n) begin
            buf_sel   <= 1'b0;
            swap_done <= 1'b0;
            first_row <= 1'b1;
            for (int i = 0; i < gpu_pkg::LINE_BUF_LEN; i++) begin
                line_buf[0][i] <= gpu_pkg::SLOT_EMPTY;
                line_buf[1][i] <= gpu_pkg::SLOT_EMPTY;
            end
        end else begin
            // row phase, reloaded at the end of each row
            if (vt.x == gpu_pkg::pos_t'(gpu_pkg::H_TOTAL - 1)) begin
                first_row <= (vt.y == gpu_pkg::pos_t'(gpu_pkg::NUM_LINES - 1)) || !first_row;
            end

            if (swap) begin
                buf_sel   <= ~buf_sel;
                swap_done <= 1'b1;
                // old front becomes the back buffer for the next parse
                for (int i = 0; i < gpu_pkg::LINE_BUF_LEN; i++) begin
                    line_buf[buf_sel][i] <= gpu_pkg::SLOT_EMPTY;
                end
            end else if (parse_en) begin
                swap_done <= 1'b0;
                if (hit) begin
                    for (int k = 0; k < gpu_pkg::SPRITE_SIZE; k++) begin
                        line_buf[~buf_sel][fill_base + gpu_pkg::pos_t'(k)] <=
                            gpu_pkg::slot_t'(mem.parse_index);
                    end
                end
            end
        end
    end

    // front buffer entry for the pixel stage
    assign draw_slot = (vt.x < gpu_pkg::LINE_BUF_LEN) ? line_buf[buf_sel][vt.x]
                                                      : gpu_pkg::SLOT_EMPTY;

    // swap falls in the hsync window, well clear of the parse
    a_swap_after_parse: assert property (
        @(posedge clk_12_5875) disable iff (!rst_n)
        swap |-> (vt.x >= gpu_pkg::NUM_OBJECTS)
    );

    // object reads only happen while hsync is idle, away from the swap
    a_parse_window: assert property (
        @(posedge clk_12_5875) disable iff (!rst_n)
        parse_en |-> vt.hsync
    );

endmodule

/* design/sprite_pixel.sv */
/*
 * pixel stage of the foreground layer
 *   - object attribute and pattern row fetch for the front slot
 *   - horizontal and vertical flip, 2-bit code select
 *   - colour enables and transparency
 *   - registered pixel with timing delayed to match
 */
module sprite_pixel (
    input  logic                 clk_12_5875,
    input  logic                 rst_n,
    video_timing_if.sink         vt,
    input  gpu_pkg::slot_t       draw_slot,
    sprite_mem_if.pixel          mem,
    output gpu_pkg::pos_t        pixel_x,
    output gpu_pkg::pos_t        pixel_y,
    output logic                 pixel_hsync,
    output logic                 pixel_vsync,
    output gpu_pkg::channel_t    r,
    output gpu_pkg::channel_t    g,
    output gpu_pkg::channel_t    b,
    output logic                 pixel_valid
);

    gpu_pkg::vram_data_t obj_x;
    gpu_pkg::vram_data_t obj_y;
    gpu_pkg::pmfa_t      pmfa;
    gpu_pkg::color_t     color;
    logic                hflip;
    logic                vflip;
    logic [2:0]          row;
    logic [2:0]          col;
    logic [2:0]          pat_row;
    logic [2:0]          pat_col;
    gpu_pkg::channel_t   code;
    logic                slot_used;
    logic                visible;
    logic                valid_d;

    // empty slot aliases object 0, its result is dropped by slot_used
    assign mem.draw_index = gpu_pkg::obj_index_t'(draw_slot);

    assign obj_x = mem.draw_attr[gpu_pkg::ATTR_X_LSB +: 8];
    assign obj_y = mem.draw_attr[gpu_pkg::ATTR_Y_LSB +: 8];
    assign pmfa  = mem.draw_attr[gpu_pkg::ATTR_PMFA_LSB +: $bits(gpu_pkg::pmfa_t)];
    assign color = mem.draw_attr[gpu_pkg::ATTR_COLOR_LSB +: $bits(gpu_pkg::color_t)];
    assign hflip = mem.draw_attr[gpu_pkg::ATTR_HFLIP_BIT];
    assign vflip = mem.draw_attr[gpu_pkg::ATTR_VFLIP_BIT];

    // position inside the 8x8 sprite, mod 8
    assign row     = vt.y[2:0] - obj_y[2:0];
    assign col     = vt.x[2:0] - obj_x[2:0];
    assign pat_row = vflip ? ~row : row;
    assign pat_col = hflip ? ~col : col;

    assign mem.pattern_sel = {pmfa, pat_row};
    // pixel 0 sits in bits 15:14
    assign code = mem.pattern_line[{~pat_col, 1'b0} +: 2];

    assign slot_used = (draw_slot != gpu_pkg::SLOT_EMPTY);
    assign visible   = (vt.x < gpu_pkg::H_VISIBLE) && (vt.y < gpu_pkg::V_VISIBLE);
    assign valid_d   = slot_used && (code != 2'd0) && visible;

    // ------------------------------------------------------------------
    // output register
    // ------------------------------------------------------------------
    always_ff @(posedge clk_12_5875) begin
        if (!rst_n) begin
            pixel_x     <= '0;
            pixel_y     <= '0;
            pixel_hsync <= 1'b1;
            pixel_vsync <= 1'b1;
            pixel_valid <= 1'b0;
        end else begin
            pixel_x     <= vt.x;
            pixel_y     <= vt.y;
            pixel_hsync <= vt.hsync;
            pixel_vsync <= vt.vsync;
            pixel_valid <= valid_d;
        end
    end

    always_ff @(posedge clk_12_5875) begin
        r <= code & {2{color[2]}};
        g <= code & {2{color[1]}};
        b <= code & {2{color[0]}};
    end

endmodule

/* design/foreground_top.sv */
/*
 * foreground layer top level
 *   - video timing, sprite memories, scanline builder, pixel stage
 *   - one timing bus and one memory bus between the blocks
 */
module foreground_top (
    input  logic                 clk_12_5875,
    input  logic                 rst_n,
    // CPU write port
    input  gpu_pkg::vram_addr_t  vram_addr,
    input  gpu_pkg::vram_data_t  vram_data,
    input  logic                 vram_we,
    // pixel output
    output gpu_pkg::pos_t        pixel_x,
    output gpu_pkg::pos_t        pixel_y,
    output logic                 pixel_hsync,
    output logic                 pixel_vsync,
    output gpu_pkg::channel_t    r,
    output gpu_pkg::channel_t    g,
    output gpu_pkg::channel_t    b,
    output logic                 pixel_valid
);

    video_timing_if  vt_bus ();
    sprite_mem_if    mem_bus ();
    gpu_pkg::slot_t  draw_slot;

    video_timing i_video_timing (
        .clk_12_5875 (clk_12_5875),
        .rst_n       (rst_n),
        .vt          (vt_bus.src)
    );

    sprite_memory i_sprite_memory (
        .clk_12_5875 (clk_12_5875),
        .vram_addr   (vram_addr),
        .vram_data   (vram_data),
        .vram_we     (vram_we),
        .mem         (mem_bus.mem)
    );

    scanline_builder i_scanline_builder (
        .clk_12_5875 (clk_12_5875),
        .rst_n       (rst_n),
        .vt          (vt_bus.sink),
        .mem         (mem_bus.builder),
        .draw_slot   (draw_slot)
    );

    sprite_pixel i_sprite_pixel (
        .clk_12_5875 (clk_12_5875),
        .rst_n       (rst_n),
        .vt          (vt_bus.sink),
        .draw_slot   (draw_slot),
        .mem         (mem_bus.pixel),
        .pixel_x     (pixel_x),
        .pixel_y     (pixel_y),
        .pixel_hsync (pixel_hsync),
        .pixel_vsync (pixel_vsync),
        .r           (r),
        .g           (g),
        .b           (b),
        .pixel_valid (pixel_valid)
    );

endmodule

/* verification/tb_foreground.sv */
/*
 * testbench for the foreground layer
 *   - clock, reset and VRAM write driver
 *   - Galois LFSR random source
 *   - shadow VRAM and expected-pixel model
 *   - compare tasks and the test sequence
 */
module tb_foreground;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int FRAME_CYCLES = gpu_pkg::H_TOTAL * gpu_pkg::NUM_ROWS;

    logic                clk_12_5875;
    logic                rst_n;
    gpu_pkg::vram_addr_t vram_addr;
    gpu_pkg::vram_data_t vram_data;
    logic                vram_we;
    gpu_pkg::pos_t       pixel_x;
    gpu_pkg::pos_t       pixel_y;
    logic                pixel_hsync;
    logic                pixel_vsync;
    gpu_pkg::channel_t   r;
    gpu_pkg::channel_t   g;
    gpu_pkg::channel_t   b;
    logic                pixel_valid;

    gpu_pkg::vram_data_t shadow_pmf [gpu_pkg::PMF_BYTES];
    gpu_pkg::vram_data_t shadow_obm [gpu_pkg::OBM_BYTES];
    logic [31:0]         lfsr_state = 32'h2b18_7eb8;
    string               test_name;
    int                  test_errors;
    int                  tests_run;
    int                  tests_failed;
    int                  total_errors;
    int                  cur_x;
    int                  cur_y;
    logic                timed_out = 1'b0;

    foreground_top i_foreground_top (.*);

    initial clk_12_5875 = 1'b0;
    always #4 clk_12_5875 = ~clk_12_5875;

    // one step per bit, taps for x^32 + x^22 + x^2 + x + 1
    function automatic int unsigned rand_bits(int n);
        int unsigned val;
        val = 0;
        for (int i = 0; i < n; i++) begin
            val = (val << 1) | lfsr_state[0];
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
        end
        return val;
    endfunction

    // ------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------
    task automatic check_pos(string what, gpu_pkg::pos_t exp, gpu_pkg::pos_t act);
        if (act !== exp) begin
            $display("ERROR %s %s at (%0d,%0d): expected %0d, actual %0d",
                     test_name, what, cur_x, cur_y, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_channel(string what, gpu_pkg::channel_t exp, gpu_pkg::channel_t act);
        if (act !== exp) begin
            $display("ERROR %s %s at (%0d,%0d): expected %0d, actual %0d",
                     test_name, what, cur_x, cur_y, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_bit(string what, logic exp, logic act);
        if (act !== exp) begin
            $display("ERROR %s %s at (%0d,%0d): expected %b, actual %b",
                     test_name, what, cur_x, cur_y, exp, act);
            test_errors++;
        end
    endtask

    // ------------------------------------------------------------------
    // VRAM writes and the shadow copy
    // ------------------------------------------------------------------
    task automatic vram_write(gpu_pkg::vram_addr_t addr, gpu_pkg::vram_data_t data);
        @(posedge clk_12_5875);
        vram_addr <= addr;
        vram_data <= data;
        vram_we   <= 1'b1;
        if (addr < 12'h200) begin
            shadow_pmf[addr] = data;
        end else if (addr >= 12'h800 && addr < 12'h900) begin
            shadow_obm[addr - 12'h800] = data;
        end
    endtask

    // flips[1] is hflip, flips[0] is vflip
    task automatic write_object(int idx, int x, int y, int flips, int pmfa, int color);
        vram_write(12'h800 + 4 * idx, x[7:0]);
        vram_write(12'h800 + 4 * idx + 1, y[7:0]);
        vram_write(12'h800 + 4 * idx + 2, {1'b0, flips[1:0], pmfa[4:0]});
        vram_write(12'h800 + 4 * idx + 3, {5'b0, color[2:0]});
    endtask

    // fold a random address into the gaps around the two windows
    function automatic gpu_pkg::vram_addr_t outside_addr(gpu_pkg::vram_addr_t a);
        if (a < 12'h200) return a + 12'h200;
        if (a >= 12'h800 && a < 12'h900) return a + 12'h100;
        return a;
    endfunction

    // ------------------------------------------------------------------
    // expected pixel, lowest overlapping index owns the pixel
    // ------------------------------------------------------------------
    task automatic model_pixel(input int x, input int y, output logic valid,
                               output gpu_pkg::channel_t er, output gpu_pkg::channel_t eg,
                               output gpu_pkg::channel_t eb);
        int                  owner;
        int                  ox;
        int                  oy;
        int                  row;
        int                  col;
        int                  base;
        logic [15:0]         line;
        gpu_pkg::vram_data_t attr2;
        gpu_pkg::vram_data_t attr3;
        gpu_pkg::channel_t   code;
        owner = -1;
        for (int i = 0; i < gpu_pkg::NUM_OBJECTS && owner < 0; i++) begin
            ox = shadow_obm[4 * i];
            oy = shadow_obm[4 * i + 1];
            if (oy <= y && y <= oy + 7 && ox <= x && x <= ox + 7) owner = i;
        end
        valid = 1'b0;
        er = '0;
        eg = '0;
        eb = '0;
        if (owner >= 0) begin
            attr2 = shadow_obm[4 * owner + 2];
            attr3 = shadow_obm[4 * owner + 3];
            row   = attr2[5] ? 7 - (y - oy) : y - oy;
            col   = attr2[6] ? 7 - (x - ox) : x - ox;
            base  = 16 * attr2[4:0] + 2 * row;
            line  = {shadow_pmf[base], shadow_pmf[base + 1]};
            code  = line[15 - 2 * col -: 2];
            valid = (code != 2'd0);
            er    = attr3[2] ? code : 2'd0;
            eg    = attr3[1] ? code : 2'd0;
            eb    = attr3[0] ? code : 2'd0;
        end
    endtask

    // pixel_y returning to line 0 marks a frame start
    task automatic wait_frame_start();
        gpu_pkg::pos_t prev_y;
        if (timed_out) return;
        prev_y = '0;
        for (int n = 0; n < 2 * FRAME_CYCLES; n++) begin
            @(negedge clk_12_5875);
            if (prev_y != 0 && pixel_y == 0) return;
            prev_y = pixel_y;
        end
        $display("%s: pixel_y never returned to line 0 within two frames", test_name);
        timed_out = 1'b1;
    endtask

    task automatic check_frame(logic with_pixels);
        logic              exp_valid;
        gpu_pkg::channel_t er;
        gpu_pkg::channel_t eg;
        gpu_pkg::channel_t eb;
        for (int row = 0; row < gpu_pkg::NUM_ROWS; row++) begin
            for (int x = 0; x < gpu_pkg::H_TOTAL; x++) begin
                cur_x = x;
                cur_y = row / gpu_pkg::LINE_REPEAT;
                check_pos("pixel_x", gpu_pkg::pos_t'(cur_x), pixel_x);
                check_pos("pixel_y", gpu_pkg::pos_t'(cur_y), pixel_y);
                check_bit("pixel_hsync", !(x >= gpu_pkg::HSYNC_START && x < gpu_pkg::HSYNC_END),
                          pixel_hsync);
                check_bit("pixel_vsync", !(cur_y == 250 || cur_y == 251), pixel_vsync);
                if (with_pixels) begin
                    exp_valid = 1'b0;
                    if (x < gpu_pkg::H_VISIBLE && cur_y < gpu_pkg::V_VISIBLE) begin
                        model_pixel(x, cur_y, exp_valid, er, eg, eb);
                    end
                    check_bit("pixel_valid", exp_valid, pixel_valid);
                    if (exp_valid) begin
                        check_channel("r", er, r);
                        check_channel("g", eg, g);
                        check_channel("b", eb, b);
                    end
                end
                @(negedge clk_12_5875);
            end
        end
    endtask

    task automatic run_frame();
        @(posedge clk_12_5875);
        vram_we <= 1'b0;
        wait_frame_start();
        wait_frame_start();
        if (!timed_out) check_frame(1'b1);
    endtask

    task automatic start_test(string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        total_errors += test_errors;
        if (test_errors != 0 || timed_out) tests_failed++;
        $display("test %-8s %s, %0d errors", test_name,
                 (test_errors == 0 && !timed_out) ? "passed" : "failed", test_errors);
    endtask

    // ------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------
    initial begin
        rst_n     = 1'b0;
        vram_addr = '0;
        vram_data = '0;
        vram_we   = 1'b0;

        start_test("reset");
        for (int i = 0; i < 10; i++) begin
            @(negedge clk_12_5875);
            check_bit("pixel_valid", 1'b0, pixel_valid);
            check_bit("pixel_hsync", 1'b1, pixel_hsync);
            check_bit("pixel_vsync", 1'b1, pixel_vsync);
        end
        @(posedge clk_12_5875);
        rst_n <= 1'b1;
        repeat (2) @(negedge clk_12_5875);
        check_pos("pixel_x", 9'd0, pixel_x);
        check_pos("pixel_y", 9'd0, pixel_y);
        check_bit("pixel_valid", 1'b0, pixel_valid);
        @(negedge clk_12_5875);
        check_pos("pixel_x", 9'd1, pixel_x);
        check_pos("pixel_y", 9'd0, pixel_y);
        finish_test();

        start_test("timing");
        wait_frame_start();
        if (!timed_out) check_frame(1'b0);
        finish_test();

        start_test("random");
        for (int i = 0; i < gpu_pkg::PMF_BYTES; i++) vram_write(i, rand_bits(8));
        for (int i = 0; i < 64; i++) begin
            write_object(i, rand_bits(8), rand_bits(8) % 240, 0, rand_bits(5), rand_bits(3));
        end
        run_frame();
        finish_test();

        start_test("flips");
        for (int i = 0; i < 64; i++) begin
            write_object(i, shadow_obm[4 * i], shadow_obm[4 * i + 1], rand_bits(2),
                         shadow_obm[4 * i + 2][4:0], shadow_obm[4 * i + 3]);
        end
        run_frame();
        finish_test();

        // groups of four objects stacked within a few pixels of each other
        start_test("priority");
        for (int i = 0; i < 64; i++) begin
            write_object(i, (i / 4) * 15 + ((i % 2) ? rand_bits(2) : 0),
                         (i / 4) * 13 + ((i % 2) ? rand_bits(2) : 0),
                         rand_bits(2), rand_bits(5), rand_bits(3));
        end
        run_frame();
        finish_test();

        start_test("addr_map");
        for (int i = 0; i < 64; i++) vram_write(outside_addr(rand_bits(12)), rand_bits(8));
        vram_write(12'h200, rand_bits(8));
        vram_write(12'h7ff, rand_bits(8));
        vram_write(12'h900, rand_bits(8));
        vram_write(12'hfff, rand_bits(8));
        run_frame();
        finish_test();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
        if (tests_failed == 0 && !timed_out) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
design/gpu_pkg.sv
design/gpu_ifs.sv
design/video_timing.sv
design/sprite_memory.sv
design/scanline_builder.sv
design/sprite_pixel.sv
design/foreground_top.sv
verification/tb_foreground.sv

/* Makefile */
# Verilator build and run of the foreground layer testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		-f tb.f --top-module tb_foreground -Mdir obj_dir -o sim_foreground

run: compile
	obj_dir/sim_foreground | tee run.log
	@if grep -q "Test FAILED" run.log; then exit 1; fi
	@grep -q "Test OK" run.log

clean:
	rm -rf obj_dir run.log
